/* mem_wb_top.f */
hdl/riscv_mem_pkg.sv
hdl/store_align.sv
hdl/load_extend.sv
hdl/data_sram.sv
hdl/mem_stage.sv
hdl/writeback_regfile.sv
hdl/mem_wb_top.sv
sim/tb_mem_wb_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the MEM/WB testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mem_wb_top.f --top-module tb_mem_wb_top -o sim_mem_wb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_mem_wb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1

/* sim/tb_mem_wb_top.sv */
`timescale 1ns/1ns

module tb_mem_wb_top;
    import riscv_mem_pkg::*;

    localparam int DMEM_W = 6; // word-address bits of the DUT memory

    typedef struct packed {
        logic     we;    // register write enable
        reg_idx_t rd;
        word_t    value; // one-hot selected result
    } stage_rec_t;

    logic        clk;
    logic        resetn;
    word_t       alu_result_e;
    dmem_op_t    dmem_op_e;
    word_t       store_data_e;
    word_t       extended_imm_e;
    word_t       pc_plus_e;
    word_t       csr_data_e;
    logic        reg_write_en_e;
    reg_idx_t    rd_idx_e;
    result_src_t result_src_e;
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       bypass_m;

    // reference models
    logic [7:0]  mem_bytes [4 * (2 ** DMEM_W)]; // little-endian bytes
    word_t       reg_model [32];
    stage_rec_t  mem_slot;   // issued last, in MEM after the next edge
    stage_rec_t  wb_slot;    // on the MEM outputs, written at the next edge
    word_t       exp_rs1;
    word_t       exp_rs2;
    word_t       exp_bypass;
    logic        check_en;
    logic [31:0] lfsr_state;
    int          check_errors;

    mem_wb_top #(
        .DMEM_ADDR_W (DMEM_W)
    ) mem_wb_top_inst (
        .clk              (clk),
        .resetn           (resetn),
        .alu_result_e_i   (alu_result_e),
        .dmem_op_e_i      (dmem_op_e),
        .store_data_e_i   (store_data_e),
        .extended_imm_e_i (extended_imm_e),
        .pc_plus_e_i      (pc_plus_e),
        .csr_data_e_i     (csr_data_e),
        .reg_write_en_e_i (reg_write_en_e),
        .rd_idx_e_i       (rd_idx_e),
        .result_src_e_i   (result_src_e),
        .rs1_idx_i        (rs1_idx),
        .rs2_idx_i        (rs2_idx),
        .rs1_data_o       (rs1_data),
        .rs2_data_o       (rs2_data),
        .bypass_m_o       (bypass_m)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk; // 100 ns period

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        check_errors++;
        $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    endtask

    // ************************************************************
    // checks, sampled at the rising edge
    // ************************************************************
    assert property (@(posedge clk) disable iff (!check_en) (rs1_data == exp_rs1))
        else report_mismatch("rs1_data_o", $sampled(rs1_data), exp_rs1);
    assert property (@(posedge clk) disable iff (!check_en) (rs2_data == exp_rs2))
        else report_mismatch("rs2_data_o", $sampled(rs2_data), exp_rs2);
    assert property (@(posedge clk) disable iff (!check_en) (bypass_m == exp_bypass))
        else report_mismatch("bypass_m_o", $sampled(bypass_m), exp_bypass);

    // galois lfsr, one step per bit taken
    function automatic word_t lfsr_bits(input int n);
        word_t val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic result_src_t src_of(input int pos);
        return result_src_t'(5'b00001 << pos);
    endfunction

    // or of every source whose select bit is set
    function automatic word_t select_result(input result_src_t src, input word_t alu,
            input word_t imm, input word_t ld, input word_t pc, input word_t csr);
        word_t val;
        val = '0;
        if (src[RES_ALU]) val = val | alu;
        if (src[RES_IMM]) val = val | imm;
        if (src[RES_MEM]) val = val | ld;
        if (src[RES_PC])  val = val | pc;
        if (src[RES_CSR]) val = val | csr;
        return val;
    endfunction

    function automatic word_t load_value(input dmem_op_t op, input word_t addr);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       w;
        b = mem_bytes[addr[DMEM_W+1:0]];
        h = {mem_bytes[{addr[DMEM_W+1:1], 1'b1}], mem_bytes[{addr[DMEM_W+1:1], 1'b0}]};
        w = {mem_bytes[{addr[DMEM_W+1:2], 2'd3}], mem_bytes[{addr[DMEM_W+1:2], 2'd2}],
             mem_bytes[{addr[DMEM_W+1:2], 2'd1}], mem_bytes[{addr[DMEM_W+1:2], 2'd0}]};
        case (op)
            DMEM_LB:  return {{24{b[7]}}, b};
            DMEM_LBU: return {24'h0, b};
            DMEM_LH:  return {{16{h[15]}}, h};
            DMEM_LHU: return {16'h0, h};
            default:  return w; // lw
        endcase
    endfunction

    task automatic store_apply(input dmem_op_t op, input word_t addr, input word_t data);
        case (op)
            DMEM_SB: mem_bytes[addr[DMEM_W+1:0]] = data[7:0];
            DMEM_SH: begin
                mem_bytes[{addr[DMEM_W+1:1], 1'b0}] = data[7:0];
                mem_bytes[{addr[DMEM_W+1:1], 1'b1}] = data[15:8];
            end
            DMEM_SW: begin
                mem_bytes[{addr[DMEM_W+1:2], 2'd0}] = data[7:0];
                mem_bytes[{addr[DMEM_W+1:2], 2'd1}] = data[15:8];
                mem_bytes[{addr[DMEM_W+1:2], 2'd2}] = data[23:16];
                mem_bytes[{addr[DMEM_W+1:2], 2'd3}] = data[31:24];
            end
            default: ; // loads and no-op
        endcase
    endtask

    // read with write-through of the instruction in write-back
    function automatic word_t model_read(input reg_idx_t idx);
        if (idx == 5'd0) return '0;
        if (wb_slot.we && (wb_slot.rd == idx)) return wb_slot.value;
        return reg_model[idx];
    endfunction

    // ************************************************************
    // one instruction per falling edge
    // ************************************************************
    task automatic issue(input dmem_op_t op, input word_t alu, input word_t sdata,
            input logic we, input reg_idx_t rd, input result_src_t src,
            input reg_idx_t r1, input reg_idx_t r2);
        word_t imm;
        word_t pc;
        word_t csr;
        word_t ld;
        @(negedge clk);
        imm = lfsr_bits(32);
        pc  = lfsr_bits(30) << 2;
        csr = lfsr_bits(32);
        if (wb_slot.we && (wb_slot.rd != 5'd0)) begin
            reg_model[wb_slot.rd] = wb_slot.value; // written at the last edge
        end
        wb_slot    = mem_slot;
        exp_bypass = wb_slot.value;
        exp_rs1    = model_read(r1);
        exp_rs2    = model_read(r2);
        ld = load_value(op, alu); // sees every earlier store
        store_apply(op, alu, sdata);
        mem_slot.we    = we;
        mem_slot.rd    = rd;
        mem_slot.value = select_result(src, alu, imm, ld, pc, csr);
        alu_result_e   = alu;
        dmem_op_e      = op;
        store_data_e   = sdata;
        extended_imm_e = imm;
        pc_plus_e      = pc;
        csr_data_e     = csr;
        reg_write_en_e = we;
        rd_idx_e       = rd;
        result_src_e   = src;
        rs1_idx        = r1;
        rs2_idx        = r2;
        check_en       = 1'b1;
    endtask

    task automatic nop_read(input reg_idx_t r1, input reg_idx_t r2);
        issue(DMEM_NO, 32'h0, 32'h0, 1'b0, 5'd0, 5'b0, r1, r2);
    endtask

    initial begin
        dmem_op_t op;
        word_t    addr;
        reg_idx_t rd;
        reg_idx_t prev_rd;
        int       k;
        lfsr_state   = 32'h594e_e64d;
        check_errors = 0;
        check_en     = 1'b0;
        mem_slot     = '0;
        wb_slot      = '0;
        for (int i = 0; i < 32; i++) reg_model[i] = '0;
        resetn = 1'b0;
        {alu_result_e, dmem_op_e, store_data_e, extended_imm_e, pc_plus_e, csr_data_e} = '0;
        {reg_write_en_e, rd_idx_e, result_src_e, rs1_idx, rs2_idx} = '0;
        for (int c = 0; c < 3; c++) @(posedge clk); // reset for 3 cycles
        @(negedge clk);
        resetn = 1'b1;

        // all registers zero, write enable low changes nothing
        for (int i = 0; i < 32; i++) begin
            issue(DMEM_NO, lfsr_bits(32), 32'h0, 1'b0, reg_idx_t'(i), src_of(RES_ALU),
                  reg_idx_t'(i), reg_idx_t'(31 - i));
        end
        // fill memory so every later load has a known word
        for (int i = 0; i < 2 ** DMEM_W; i++) begin
            issue(DMEM_SW, word_t'(i * 4), lfsr_bits(32), 1'b0, 5'd0, src_of(RES_ALU), 5'd0, 5'd0);
        end

        // ************************************************************
        // sub-word stores, read back by lw
        // ************************************************************
        issue(DMEM_SW, 32'h48, lfsr_bits(32), 1'b0, 5'd0, src_of(RES_ALU), 5'd0, 5'd0);
        issue(DMEM_LW, 32'h48, 32'h0, 1'b1, 5'd3, src_of(RES_MEM), 5'd0, 5'd0);
        for (int off = 0; off < 4; off++) begin
            issue(DMEM_SB, 32'h40 + off, lfsr_bits(32), 1'b0, 5'd0, src_of(RES_ALU), 5'd3, 5'd0);
            issue(DMEM_LW, 32'h40, 32'h0, 1'b1, 5'd3, src_of(RES_MEM), 5'd3, 5'd0);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue(DMEM_SH, 32'h44 + off, lfsr_bits(32), 1'b0, 5'd0, src_of(RES_ALU), 5'd4, 5'd0);
            issue(DMEM_LW, 32'h44, 32'h0, 1'b1, 5'd4, src_of(RES_MEM), 5'd4, 5'd3);
        end

        // byte and half loads, back to back, both sign cases
        issue(DMEM_SW, 32'h80, 32'h80FF_7F01, 1'b0, 5'd0, src_of(RES_ALU), 5'd0, 5'd0);
        for (int off = 0; off < 4; off++) begin
            issue(DMEM_LB, 32'h80 + off, 32'h0, 1'b1, 5'd1, src_of(RES_MEM), 5'd2, 5'd1);
            issue(DMEM_LBU, 32'h80 + off, 32'h0, 1'b1, 5'd2, src_of(RES_MEM), 5'd1, 5'd2);
            if (off % 2 == 0) begin
                issue(DMEM_LH, 32'h80 + off, 32'h0, 1'b1, 5'd1, src_of(RES_MEM), 5'd2, 5'd1);
                issue(DMEM_LHU, 32'h80 + off, 32'h0, 1'b1, 5'd2, src_of(RES_MEM), 5'd1, 5'd2);
            end
        end

        // each result source into its own rd, read during write-back
        for (int s = 0; s < 5; s++) begin
            issue((s == RES_MEM) ? DMEM_LW : DMEM_NO, 32'h1234_5648, 32'h0, 1'b1,
                  reg_idx_t'(5 + s), src_of(s), reg_idx_t'(4 + s), 5'd5);
        end
        nop_read(5'd9, 5'd5);
        // x0 stays zero
        issue(DMEM_NO, 32'hDEAD_BEEF, 32'h0, 1'b1, 5'd0, src_of(RES_ALU), 5'd0, 5'd0);
        nop_read(5'd0, 5'd0);
        nop_read(5'd0, 5'd9);

        // ************************************************************
        // random mix, rs1 follows the previous rd
        // ************************************************************
        prev_rd = 5'd0;
        for (int i = 0; i < 200; i++) begin
            op   = dmem_op_t'(lfsr_bits(4) % 9);
            addr = lfsr_bits(32);
            if (op inside {DMEM_LH, DMEM_LHU, DMEM_SH}) addr[0] = 1'b0;
            if (op inside {DMEM_LW, DMEM_SW}) addr[1:0] = 2'b00;
            rd = reg_idx_t'(lfsr_bits(5));
            k  = int'(lfsr_bits(2));
            if (k == RES_MEM) k = RES_CSR; // memory only for loads
            if (op inside {DMEM_LB, DMEM_LH, DMEM_LW, DMEM_LBU, DMEM_LHU}) k = RES_MEM;
            issue(op, addr, lfsr_bits(32), !(op inside {DMEM_SB, DMEM_SH, DMEM_SW}), rd,
                  src_of(k), prev_rd, reg_idx_t'(lfsr_bits(5)));
            prev_rd = rd;
        end

        // empty the pipeline, MEM and WB, then sweep the file
        nop_read(5'd0, 5'd0);
        nop_read(5'd0, 5'd0);
        for (int i = 0; i < 32; i++) nop_read(reg_idx_t'(i), reg_idx_t'(31 - i));
        @(negedge clk);
        check_en = 1'b0;

        $display("errors: %0d value mismatches", check_errors);
        if (check_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        for (int c = 0; c < 2000; c++) @(posedge clk);
        $display("timeout, stimulus did not finish within 2000 clock cycles");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* hdl/mem_wb_top.sv */
`timescale 1ns/1ns

// MEM and WB end of the pipeline
module mem_wb_top #(
    parameter int DMEM_ADDR_W = riscv_mem_pkg::DMEM_ADDR_W
) (
    input  logic                       clk,
    input  logic                       resetn,

    // execute stage outputs
    input  riscv_mem_pkg::word_t       alu_result_e_i,
    input  riscv_mem_pkg::dmem_op_t    dmem_op_e_i,
    input  riscv_mem_pkg::word_t       store_data_e_i,
    input  riscv_mem_pkg::word_t       extended_imm_e_i,
    input  riscv_mem_pkg::word_t       pc_plus_e_i,
    input  riscv_mem_pkg::word_t       csr_data_e_i,
    input  logic                       reg_write_en_e_i,
    input  riscv_mem_pkg::reg_idx_t    rd_idx_e_i,
    input  riscv_mem_pkg::result_src_t result_src_e_i,

    // decode read ports
    input  riscv_mem_pkg::reg_idx_t    rs1_idx_i,
    input  riscv_mem_pkg::reg_idx_t    rs2_idx_i,
    output riscv_mem_pkg::word_t       rs1_data_o,
    output riscv_mem_pkg::word_t       rs2_data_o,

    output riscv_mem_pkg::word_t       bypass_m_o  // forwarding from MEM
);
    import riscv_mem_pkg::*;

    // mem -> wb
    word_t       alu_result_m;
    word_t       extended_imm_m;
    word_t       pc_plus_m;
    word_t       csr_data_m;
    word_t       mem_read_data_m;
    logic        reg_write_en_m;
    reg_idx_t    rd_idx_m;
    result_src_t result_src_m;

    mem_stage #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) mem_stage_inst (
        .clk               (clk),
        .resetn            (resetn),
        .alu_result_e_i    (alu_result_e_i),
        .dmem_op_e_i       (dmem_op_e_i),
        .store_data_e_i    (store_data_e_i),
        .extended_imm_e_i  (extended_imm_e_i),
        .pc_plus_e_i       (pc_plus_e_i),
        .csr_data_e_i      (csr_data_e_i),
        .reg_write_en_e_i  (reg_write_en_e_i),
        .rd_idx_e_i        (rd_idx_e_i),
        .result_src_e_i    (result_src_e_i),
        .alu_result_m_o    (alu_result_m),
        .extended_imm_m_o  (extended_imm_m),
        .pc_plus_m_o       (pc_plus_m),
        .csr_data_m_o      (csr_data_m),
        .mem_read_data_m_o (mem_read_data_m),
        .reg_write_en_m_o  (reg_write_en_m),
        .rd_idx_m_o        (rd_idx_m),
        .result_src_m_o    (result_src_m),
        .bypass_m_o        (bypass_m_o)
    );

    writeback_regfile writeback_regfile_inst (
        .clk             (clk),
        .resetn          (resetn),
        .alu_result_i    (alu_result_m),
        .extended_imm_i  (extended_imm_m),
        .pc_plus_i       (pc_plus_m),
        .csr_data_i      (csr_data_m),
        .mem_read_data_i (mem_read_data_m),
        .result_src_i    (result_src_m),
        .reg_write_en_i  (reg_write_en_m),
        .rd_idx_i        (rd_idx_m),
        .rs1_idx_i       (rs1_idx_i),
        .rs2_idx_i       (rs2_idx_i),
        .rs1_data_o      (rs1_data_o),
        .rs2_data_o      (rs2_data_o)
    );

endmodule

/* hdl/writeback_regfile.sv */
`timescale 1ns/1ns

// write-back select and the 32-entry register file, x0 tied to zero
module writeback_regfile (
    input  logic                       clk,
    input  logic                       resetn,

    // from MEM
    input  riscv_mem_pkg::word_t       alu_result_i,
    input  riscv_mem_pkg::word_t       extended_imm_i,
    input  riscv_mem_pkg::word_t       pc_plus_i,
    input  riscv_mem_pkg::word_t       csr_data_i,
    input  riscv_mem_pkg::word_t       mem_read_data_i,
    input  riscv_mem_pkg::result_src_t result_src_i,   // one-hot
    input  logic                       reg_write_en_i,
    input  riscv_mem_pkg::reg_idx_t    rd_idx_i,

    // decode read ports
    input  riscv_mem_pkg::reg_idx_t    rs1_idx_i,
    input  riscv_mem_pkg::reg_idx_t    rs2_idx_i,
    output riscv_mem_pkg::word_t       rs1_data_o,
    output riscv_mem_pkg::word_t       rs2_data_o
);
    import riscv_mem_pkg::*;

    word_t wb_value;      // selected result
    logic  wb_write;      // write at next edge
    word_t regs [1:31];   // x1..x31

    // ************************************************************
    // result select, or of masked sources
    // ************************************************************
    assign wb_value = ({32{result_src_i[RES_ALU]}} & alu_result_i)    |
                      ({32{result_src_i[RES_IMM]}} & extended_imm_i)  |
                      ({32{result_src_i[RES_MEM]}} & mem_read_data_i) |
                      ({32{result_src_i[RES_PC]}}  & pc_plus_i)       |
                      ({32{result_src_i[RES_CSR]}} & csr_data_i);

    assign wb_write = reg_write_en_i && (rd_idx_i != 5'd0); // x0 never written

    // ************************************************************
    // register array
    // ************************************************************
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[rd_idx_i] <= wb_value;
        end
    end

    // read with write-through of the value being written back
    function automatic word_t read_port(input reg_idx_t idx);
        word_t data;
        if (idx == 5'd0) begin
            data = '0;
        end else if (wb_write && (idx == rd_idx_i)) begin
            data = wb_value; // bypass the array
        end else begin
            data = regs[idx];
        end
        return data;
    endfunction

    assign rs1_data_o = read_port(rs1_idx_i);
    assign rs2_data_o = read_port(rs2_idx_i);

endmodule

/* hdl/mem_stage.sv */
`timescale 1ns/1ns

// MEM pipeline stage: exe/mem registers, data sram access, load path, bypass
module mem_stage #(
    parameter int DMEM_ADDR_W = riscv_mem_pkg::DMEM_ADDR_W
) (
    input  logic                       clk,
    input  logic                       resetn,

    // from execute
    input  riscv_mem_pkg::word_t       alu_result_e_i,   // also the memory address
    input  riscv_mem_pkg::dmem_op_t    dmem_op_e_i,
    input  riscv_mem_pkg::word_t       store_data_e_i,
    input  riscv_mem_pkg::word_t       extended_imm_e_i,
    input  riscv_mem_pkg::word_t       pc_plus_e_i,
    input  riscv_mem_pkg::word_t       csr_data_e_i,
    input  logic                       reg_write_en_e_i,
    input  riscv_mem_pkg::reg_idx_t    rd_idx_e_i,
    input  riscv_mem_pkg::result_src_t result_src_e_i,

    // to write-back
    output riscv_mem_pkg::word_t       alu_result_m_o,
    output riscv_mem_pkg::word_t       extended_imm_m_o,
    output riscv_mem_pkg::word_t       pc_plus_m_o,
    output riscv_mem_pkg::word_t       csr_data_m_o,
    output riscv_mem_pkg::word_t       mem_read_data_m_o, // extended load data
    output logic                       reg_write_en_m_o,
    output riscv_mem_pkg::reg_idx_t    rd_idx_m_o,
    output riscv_mem_pkg::result_src_t result_src_m_o,

    // forwarding to execute
    output riscv_mem_pkg::word_t       bypass_m_o
);
    import riscv_mem_pkg::*;

    // sram side
    logic                   sram_ce;
    logic                   sram_we;
    logic [DMEM_ADDR_W-1:0] sram_addr;
    byte_en_t               sram_byte_en;
    word_t                  sram_wdata;
    word_t                  sram_rdata;

    // load path, registered at the same edge as the sram read
    dmem_op_t               dmem_op_m;
    logic [1:0]             addr_lo_m;

    // ************************************************************
    // sram control
    // ************************************************************
    assign sram_ce   = (dmem_op_e_i != DMEM_NO);
    assign sram_we   = (dmem_op_e_i == DMEM_SB) ||
                       (dmem_op_e_i == DMEM_SH) ||
                       (dmem_op_e_i == DMEM_SW);
    assign sram_addr = alu_result_e_i[DMEM_ADDR_W+1:2]; // word address

    store_align store_align_inst (
        .op_i         (dmem_op_e_i),
        .addr_lo_i    (alu_result_e_i[1:0]),
        .store_data_i (store_data_e_i),
        .wdata_o      (sram_wdata),
        .byte_en_o    (sram_byte_en)
    );

    data_sram #(
        .ADDR_W (DMEM_ADDR_W)
    ) data_sram_inst (
        .clk       (clk),
        .ce_i      (sram_ce),
        .we_i      (sram_we),
        .addr_i    (sram_addr),
        .byte_en_i (sram_byte_en),
        .wdata_i   (sram_wdata),
        .rdata_o   (sram_rdata)
    );

    // ************************************************************
    // exe/mem registers
    // ************************************************************
    always_ff @(posedge clk) begin
        if (!resetn) begin
            reg_write_en_m_o <= 1'b0;
            result_src_m_o   <= '0;
            dmem_op_m        <= DMEM_NO;
        end else begin
            reg_write_en_m_o <= reg_write_en_e_i;
            result_src_m_o   <= result_src_e_i;
            dmem_op_m        <= dmem_op_e_i;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        alu_result_m_o   <= alu_result_e_i;
        extended_imm_m_o <= extended_imm_e_i;
        pc_plus_m_o      <= pc_plus_e_i;
        csr_data_m_o     <= csr_data_e_i;
        rd_idx_m_o       <= rd_idx_e_i;
        addr_lo_m        <= alu_result_e_i[1:0]; // byte offset for the load
    end

    // sram word arrives with dmem_op_m and addr_lo_m
    load_extend load_extend_inst (
        .op_i        (dmem_op_m),
        .addr_lo_i   (addr_lo_m),
        .rdata_i     (sram_rdata),
        .load_data_o (mem_read_data_m_o)
    );

    // ************************************************************
    // forwarding value of the instruction in MEM
    // ************************************************************
    assign bypass_m_o = ({32{result_src_m_o[RES_ALU]}} & alu_result_m_o)    |
                        ({32{result_src_m_o[RES_IMM]}} & extended_imm_m_o)  |
                        ({32{result_src_m_o[RES_MEM]}} & mem_read_data_m_o) |
                        ({32{result_src_m_o[RES_PC]}}  & pc_plus_m_o)       |
                        ({32{result_src_m_o[RES_CSR]}} & csr_data_m_o);

endmodule

/* hdl/data_sram.sv */
`timescale 1ns/1ns

// single-port data memory, byte mask on write, one-cycle registered read
module data_sram #(
    parameter int ADDR_W = riscv_mem_pkg::DMEM_ADDR_W
) (
    input  logic                    clk,
    input  logic                    ce_i,      // access this cycle
    input  logic                    we_i,      // write when ce_i also high
    input  logic [ADDR_W-1:0]       addr_i,    // word address
    input  riscv_mem_pkg::byte_en_t byte_en_i, // lane mask for writes
    input  riscv_mem_pkg::word_t    wdata_i,
    output riscv_mem_pkg::word_t    rdata_o    // valid the cycle after ce_i
);
    import riscv_mem_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    word_t mem [DEPTH]; // contents undefined after power-up

    // ************************************************************
    // write port, enabled lanes only
    // ************************************************************
    always_ff @(posedge clk) begin
        if (ce_i && we_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_en_i[lane]) begin
                    mem[addr_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
                end
            end
        end
    end

    // ************************************************************
    // read port
    // ************************************************************
    // nonblocking, so a read during a write sees the old word
    always_ff @(posedge clk) begin
        if (ce_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

/* hdl/load_extend.sv */
`timescale 1ns/1ns

// picks the loaded byte or halfword out of the sram word and extends it
module load_extend (
    input  riscv_mem_pkg::dmem_op_t op_i,      // registered with the read
    input  logic [1:0]              addr_lo_i, // registered byte offset
    input  riscv_mem_pkg::word_t    rdata_i,   // sram output
    output riscv_mem_pkg::word_t    load_data_o
);
    import riscv_mem_pkg::*;

    logic [7:0]  sel_byte; // byte at the offset
    logic [15:0] sel_half; // halfword at the offset

    // ************************************************************
    // lane select
    // ************************************************************
    always_comb begin
        case (addr_lo_i)
            2'b00:   sel_byte = rdata_i[7:0];
            2'b01:   sel_byte = rdata_i[15:8];
            2'b10:   sel_byte = rdata_i[23:16];
            default: sel_byte = rdata_i[31:24];
        endcase
    end

    // only bit 1 matters for halfwords
    always_comb begin
        if (addr_lo_i[1]) begin
            sel_half = rdata_i[31:16];
        end else begin
            sel_half = rdata_i[15:0];
        end
    end

    // ************************************************************
    // extension
    // ************************************************************
    always_comb begin
        case (op_i)
            DMEM_LB: begin
                load_data_o = {{24{sel_byte[7]}}, sel_byte};  // sign
            end
            DMEM_LH: begin
                load_data_o = {{16{sel_half[15]}}, sel_half}; // sign
            end
            DMEM_LBU: begin
                load_data_o = {24'h0, sel_byte};              // zero
            end
            DMEM_LHU: begin
                load_data_o = {16'h0, sel_half};              // zero
            end
            default: begin
                // lw, stores and no-op see the raw word
                load_data_o = rdata_i;
            end
        endcase
    end

endmodule

/* hdl/store_align.sv */
`timescale 1ns/1ns

// places store data on the byte lanes picked by the low address bits
module store_align (
    input  riscv_mem_pkg::dmem_op_t op_i,
    input  logic [1:0]              addr_lo_i,    // byte offset in the word
    input  riscv_mem_pkg::word_t    store_data_i, // rs2 value from execute
    output riscv_mem_pkg::word_t    wdata_o,
    output riscv_mem_pkg::byte_en_t byte_en_o
);
    import riscv_mem_pkg::*;

    always_comb begin
        // defaults, no lane written
        wdata_o   = store_data_i;
        byte_en_o = 4'b0000;

        case (op_i)
            DMEM_SB: begin
                // low byte copied to every lane, mask picks one
                wdata_o = {4{store_data_i[7:0]}};
                case (addr_lo_i)
                    2'b00:   byte_en_o = 4'b0001;
                    2'b01:   byte_en_o = 4'b0010;
                    2'b10:   byte_en_o = 4'b0100;
                    default: byte_en_o = 4'b1000;
                endcase
            end

            DMEM_SH: begin
                wdata_o = {2{store_data_i[15:0]}}; // both halves
                if (addr_lo_i[1]) begin
                    byte_en_o = 4'b1100; // upper half
                end else begin
                    byte_en_o = 4'b0011; // lower half
                end
                // addr bit 0 ignored, no misaligned trap here
            end

            DMEM_SW: begin
                wdata_o   = store_data_i;
                byte_en_o = 4'b1111;
            end

            default: begin
                // loads and no-op leave the mask at zero
                byte_en_o = 4'b0000;
            end
        endcase
    end

endmodule

/* hdl/riscv_mem_pkg.sv */
// shared types and codes for the MEM and WB stages of the rv32i pipeline
package riscv_mem_pkg;

    // ************************************************************
    // widths with a meaning
    // ************************************************************
    typedef logic [31:0] word_t;       // data or address word
    typedef logic [4:0]  reg_idx_t;    // x0..x31
    typedef logic [3:0]  byte_en_t;    // one bit per byte lane, bit 0 = lane 0
    typedef logic [3:0]  dmem_op_t;    // load/store operation code
    typedef logic [4:0]  result_src_t; // one-hot write-back select

    // default data memory depth in words, as log2
    localparam int DMEM_ADDR_W = 10;

    // ************************************************************
    // load/store operation codes
    // ************************************************************
    localparam dmem_op_t DMEM_NO  = 4'd0; // no memory access
    localparam dmem_op_t DMEM_LB  = 4'd1;
    localparam dmem_op_t DMEM_LH  = 4'd2;
    localparam dmem_op_t DMEM_LW  = 4'd3;
    localparam dmem_op_t DMEM_LBU = 4'd4;
    localparam dmem_op_t DMEM_LHU = 4'd5;
    localparam dmem_op_t DMEM_SB  = 4'd6;
    localparam dmem_op_t DMEM_SH  = 4'd7;
    localparam dmem_op_t DMEM_SW  = 4'd8;

    // ************************************************************
    // bit positions in result_src_t
    // ************************************************************
    localparam int RES_ALU = 0; // alu result
    localparam int RES_IMM = 1; // extended immediate, lui
    localparam int RES_MEM = 2; // load data
    localparam int RES_PC  = 3; // pc + 4, jal / jalr
    localparam int RES_CSR = 4; // csr read data

endpackage
